// ==== all.f ====
+incdir+include
hw/cpu_pkg.sv
hw/cycle_sequencer.sv
hw/cond_eval.sv
hw/cex_tracker.sv
hw/psw_unit.sv
hw/ctrl_word_gen.sv
hw/cpu_control_top.sv
dv/tb_cpu_control.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_cpu_control -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "Test completed successfully"; then
	exit 0
fi
exit 1

// ==== dv/tb_cpu_control.sv ====
`include "cpu_params.svh"

module tb_cpu_control;
	timeunit 1ns;
	timeprecision 1ps;

	import cpu_pkg::*;

	localparam int WAIT_LIMIT = 64; // Clocks before a wait gives up

	typedef struct packed
	{
		ctrl_word_t ctrl; // Expected control word
		ctrl_word_t mask; // Fields that the rules fix
		logic [1:0] n_exec; // Execute steps
		psw_t psw; // PSW after the instruction
	} expect_t;

	logic clock;
	logic cpucycle_rst;
	logic [`CPU_WORD_W-1:0] pc;
	logic [`CPU_WORD_W-1:0] brkpnt;
	instr_t dec;
	logic dec_valid;
	flags_t alu_flags;
	logic flags_valid;
	logic dec_ready;
	ctrl_word_t ctrl;
	step_e step;
	psw_t psw;
	logic brk_hit;

	instr_t cur_instr; // Instruction in execution
	psw_t model_psw;
	expect_t cmp_exp;
	logic cx_active; // CEX model state
	logic cx_result;
	int cx_t;
	int cx_f;
	int errors;
	int err_mark; // Errors before the running test
	int checks;
	int tests;

	cpu_control_top u_dut
	(
		.clock(clock),
		.cpucycle_rst(cpucycle_rst),
		.pc(pc),
		.brkpnt(brkpnt),
		.dec(dec),
		.dec_valid(dec_valid),
		.alu_flags(alu_flags),
		.flags_valid(flags_valid),
		.dec_ready(dec_ready),
		.ctrl(ctrl),
		.step(step),
		.psw(psw),
		.brk_hit(brk_hit)
	);

	always #20 clock = ~clock; // 40 ns period

	function automatic logic cond_holds(input logic [3:0] code, input psw_t p);
		logic ge;
		ge = ~(p.n ^ p.v); // n equals v
		case (code)
			4'd0: return p.z;
			4'd1: return ~p.z;
			4'd2: return p.c;
			4'd3: return ~p.c;
			4'd4: return p.n;
			4'd5: return ~p.n;
			4'd6: return p.v;
			4'd7: return ~p.v;
			4'd8: return p.c & ~p.z; // HI
			4'd9: return ~p.c | p.z; // LS
			4'd10: return ge;
			4'd11: return ~ge;
			4'd12: return ~p.z & ge; // GT
			4'd13: return p.z | ~ge; // LE
			4'd14: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [3:0] branch_code(input opcode_e op);
		if (int'(op) <= 5)
			return 4'(int'(op) - 1); // BEQ to BN give EQ to MI
		return 4'(int'(op) + 4); // BGE to BRA give GE to GT
	endfunction

	function automatic expect_t expected_step(input instr_t in, input psw_t p, input step_e st);
		expect_t e;
		logic [4:0] src;
		logic [4:0] dst;
		int k;
		e = '0;
		e.mask.dbus.en = 1'b1; // Idle unless a rule says otherwise
		e.mask.abus.en = 1'b1;
		e.mask.mem.ena = 1'b1;
		e.mask.psw_update = 1'b1;
		e.n_exec = 2'd1;
		e.psw = p;
		src = {2'b00, in.opnd.regop.src};
		dst = {2'b00, in.opnd.regop.dst};
		case (in.op)
			BL: e.n_exec = 2'd2;
			LD, ST: e.n_exec = 2'd3;
			SETCC: e.psw[4:0] = p[4:0] | in.opnd.pswop.pswb;
			CLRCC: e.psw[4:0] = p[4:0] & ~in.opnd.pswop.pswb;
			SETPRI:
			begin
				if (in.opnd.pswop.pr < p.cur_pri)
					e.psw.cur_pri = in.opnd.pswop.pr; // Only a lower priority is taken
			end
			default: e.n_exec = 2'd1;
		endcase
		if (st == EXEC1)
		begin
			case (in.op)
				ADD, ADDC, SUB, SUBC, DADD, CMP, XOR, AND, OR, BIT, BIC, BIS, SRA, RRC:
				begin
					k = ((in.op == SRA) || (in.op == RRC)) ? 11 : 9;
					e.ctrl.alu_op = 6'(2 * (int'(in.op) - k) + int'(in.opnd.regop.wb));
					e.ctrl.alu_dst = dst;
					e.ctrl.alu_src = 5'(src + (in.opnd.regop.rc ? 5'd8 : 5'd0));
					e.ctrl.dbus.en = 1'b1;
					e.ctrl.dbus.src = ALU; // ALU result to register
					e.ctrl.dbus.dst = REG;
					e.ctrl.psw_update = 1'b1;
					e.mask.alu_op = '1;
					e.mask.alu_dst = '1;
					e.mask.alu_src = '1;
					e.mask.dbus.src = bus_port_e'(2'b11);
					e.mask.dbus.dst = bus_port_e'(2'b11);
				end
				MOV:
				begin
					e.ctrl.dbus.en = 1'b1;
					e.ctrl.dbus.src = REG;
					e.ctrl.dbus.dst = REG;
					e.ctrl.dbus_src = src;
					e.ctrl.dbus_dst = dst;
					e.mask.dbus.src = bus_port_e'(2'b11);
					e.mask.dbus.dst = bus_port_e'(2'b11);
					e.mask.dbus_src = '1;
					e.mask.dbus_dst = '1;
				end
				BEQ, BNE, BC, BNC, BN, BGE, BLT, BRA:
				begin
					if (cond_holds(branch_code(in.op), p)) // Taken writes PC + offset
					begin
						e.ctrl.dbus.en = 1'b1;
						e.ctrl.dbus.src = ALU;
						e.ctrl.dbus.dst = REG;
						e.ctrl.dbus_dst = `CPU_PC_REG;
						e.ctrl.alu_dst = `CPU_PC_REG;
						e.ctrl.s_sel = 1'b1;
						e.mask.dbus.src = bus_port_e'(2'b11);
						e.mask.dbus.dst = bus_port_e'(2'b11);
						e.mask.dbus_dst = '1;
						e.mask.alu_dst = '1;
						e.mask.s_sel = 1'b1;
					end
				end
				BL:
				begin
					e.ctrl.dbus.en = 1'b1; // PC copied to LR
					e.ctrl.dbus_src = `CPU_PC_REG;
					e.ctrl.dbus_dst = `CPU_LR_REG;
					e.mask.dbus_src = '1;
					e.mask.dbus_dst = '1;
				end
				LD, ST:
				begin
					e.ctrl.abus.en = 1'b1; // Address register out
					e.mask.mem.ena = 1'b0;
				end
				default: e.mask.alu_op = '0;
			endcase
		end
		else if (st == EXEC2)
		begin
			case (in.op)
				BL:
				begin
					e.ctrl.dbus.en = 1'b1; // Sum into PC
					e.ctrl.dbus.src = ALU;
					e.ctrl.dbus_dst = `CPU_PC_REG;
					e.mask.dbus.src = bus_port_e'(2'b11);
					e.mask.dbus_dst = '1;
				end
				LD, ST:
				begin
					e.ctrl.dbus.en = 1'b1; // Data moves
					e.mask.mem.ena = 1'b0;
				end
				default: e.mask.alu_op = '0;
			endcase
		end
		return e;
	endfunction

	function automatic logic cex_allows();
		if (!cx_active)
			return 1'b1;
		return (cx_result && (cx_t > 0)) || (!cx_result && (cx_t == 0) && (cx_f > 0));
	endfunction

	task automatic consume_cex();
		if (cx_t > 0)
			cx_t = cx_t - 1; // True slots first
		else if (cx_f > 0)
			cx_f = cx_f - 1;
		if ((cx_t == 0) && (cx_f == 0))
			cx_active = 1'b0;
	endtask

	task automatic hang_abort(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Test failed");
		$finish;
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		tests = tests + 1;
		$display("%s finished with %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	task automatic wait_for_decode();
		int guard;
		guard = 0;
		while (step != DECODE)
		begin
			@(negedge clock);
			guard = guard + 1;
			if (guard > WAIT_LIMIT)
				hang_abort("the DECODE step");
		end
	endtask

	task automatic set_flags(input flags_t f);
		alu_flags = f;
		flags_valid = 1'b1;
		@(negedge clock); // One load pulse
		flags_valid = 1'b0;
		model_psw.v = f.v;
		model_psw.n = f.n;
		model_psw.z = f.z;
		model_psw.c = f.c;
	endtask

	task automatic run_instr(input instr_t in);
		expect_t e;
		logic allow;
		int n;
		int guard;
		wait_for_decode();
		check_value("dec_ready", 32'(dec_ready), 32'd1);
		check_value("psw", 32'(psw), 32'(model_psw));
		allow = cex_allows();
		cur_instr = in;
		dec = in;
		dec_valid = 1'b1;
		@(negedge clock); // Handshake on the edge in between
		dec_valid = 1'b0;
		consume_cex();
		n = 0;
		guard = 0;
		while (step != FETCH1)
		begin
			n = n + 1;
			@(negedge clock);
			guard = guard + 1;
			if (guard > WAIT_LIMIT)
				hang_abort("the return to FETCH1");
		end
		e = expected_step(in, model_psw, EXEC1);
		check_value("exec steps", 32'(n),
			allow ? 32'(e.n_exec) : 32'd0); // Skip is DECODE then FETCH1
		if (allow)
		begin
			if (in.op == CEX)
			begin
				cx_active = 1'b1;
				cx_result = cond_holds(in.opnd.cexop.c, model_psw);
				cx_t = int'(in.opnd.cexop.t);
				cx_f = int'(in.opnd.cexop.f);
			end
			model_psw = e.psw;
		end
	endtask

	function automatic instr_t reg_instr(input opcode_e op);
		instr_t x;
		x = '0;
		x.op = op;
		x.opnd.regop.rc = 1'($urandom_range(0, 1));
		x.opnd.regop.wb = 1'($urandom_range(0, 1));
		x.opnd.regop.src = 3'($urandom_range(0, 7));
		x.opnd.regop.dst = 3'($urandom_range(0, 7));
		return x;
	endfunction

	function automatic opcode_e rand_alu_op();
		int r;
		r = int'($urandom_range(0, 13));
		if (r < 12)
			return opcode_e'(7'(9 + r)); // ADD to BIS
		return opcode_e'(7'(11 + r)); // SRA and RRC
	endfunction

	// Checks the control word in every execute step
	always @(negedge clock)
	begin
		if (!cpucycle_rst && ((step == EXEC1) || (step == EXEC2) || (step == EXEC3)))
		begin
			cmp_exp = expected_step(cur_instr, model_psw, step);
			checks = checks + 1;
			if ((ctrl & cmp_exp.mask) != (cmp_exp.ctrl & cmp_exp.mask))
			begin
				errors = errors + 1;
				$display("Error: ctrl in %s for op %h got %h expected %h", step.name(),
					cur_instr.op, ctrl & cmp_exp.mask, cmp_exp.ctrl & cmp_exp.mask);
			end
		end
	end

	initial
	begin
		instr_t x;
		int t;
		int f;
		clock = 1'b0;
		cpucycle_rst = 1'b1;
		pc = 16'h0100;
		brkpnt = 16'h8000; // Away from pc
		dec = '0;
		dec_valid = 1'b0;
		alu_flags = '0;
		flags_valid = 1'b0;
		cur_instr = '0;
		model_psw = psw_t'(`CPU_PSW_RESET);
		cx_active = 1'b0;
		cx_result = 1'b0;
		cx_t = 0;
		cx_f = 0;
		errors = 0;
		err_mark = 0;
		checks = 0;
		tests = 0;
		void'($urandom(32'h0de893e8));
		repeat (4) @(negedge clock); // Four reset cycles
		check_value("step", 32'(step), 32'(FETCH1));
		check_value("dec_ready", 32'(dec_ready), 32'd0);
		check_value("brk_hit", 32'(brk_hit), 32'd0);
		check_value("ctrl.dbus.en", 32'(ctrl.dbus.en), 32'd0);
		check_value("ctrl.psw_update", 32'(ctrl.psw_update), 32'd0);
		check_value("psw", 32'(psw), 32'(`CPU_PSW_RESET));
		cpucycle_rst = 1'b0;
		end_test("reset");

		repeat (20) run_instr(reg_instr(rand_alu_op()));
		repeat (4) run_instr(reg_instr(MOV));
		run_instr(reg_instr(LD)); // Three execute steps each
		run_instr(reg_instr(ST));
		run_instr(reg_instr(BL));
		end_test("alu, mov, ld and st");

		for (int op = 1; op <= 8; op++)
		begin
			repeat (4)
			begin
				wait_for_decode();
				set_flags(flags_t'($urandom_range(0, 15)));
				x = '0;
				x.op = opcode_e'(7'(op));
				x.opnd.branch.off = 13'($urandom);
				run_instr(x);
			end
		end
		end_test("branch");

		repeat (8)
		begin
			wait_for_decode();
			set_flags(flags_t'($urandom_range(0, 15)));
			t = int'($urandom_range(0, 3));
			f = int'($urandom_range(0, 3));
			x = '0;
			x.op = CEX;
			x.opnd.cexop.c = 4'($urandom_range(0, 15));
			x.opnd.cexop.t = 3'(t);
			x.opnd.cexop.f = 3'(f);
			run_instr(x);
			repeat (t + f + 1) run_instr(reg_instr(rand_alu_op())); // Drains the CEX block
		end
		end_test("cex");

		x = '0;
		x.op = SETCC;
		x.opnd.pswop.pswb = 5'($urandom_range(1, 31));
		run_instr(x);
		check_value("psw", 32'(psw), 32'(model_psw));
		x.op = CLRCC;
		x.opnd.pswop.pswb = 5'($urandom_range(1, 31));
		run_instr(x);
		check_value("psw", 32'(psw), 32'(model_psw));
		x.op = SETPRI;
		x.opnd.pswop.pr = 3'($urandom_range(0, int'(model_psw.cur_pri) - 1)); // Lower
		run_instr(x);
		check_value("psw", 32'(psw), 32'(model_psw));
		x.opnd.pswop.pr = 3'($urandom_range(int'(model_psw.cur_pri) + 1, 7)); // Higher, ignored
		run_instr(x);
		check_value("psw", 32'(psw), 32'(model_psw));
		end_test("psw operations");

		wait_for_decode();
		brkpnt = pc;
		run_instr(reg_instr(MOV)); // Ends in FETCH1 on the breakpoint
		repeat (5)
		begin
			check_value("step", 32'(step), 32'(FETCH1));
			check_value("brk_hit", 32'(brk_hit), 32'd1);
			@(negedge clock);
		end
		pc = pc + 16'd2;
		@(negedge clock);
		check_value("step", 32'(step), 32'(FETCH2));
		check_value("brk_hit", 32'(brk_hit), 32'd0);
		run_instr(reg_instr(MOV));
		end_test("breakpoint");

		$display("Tests run %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end
endmodule

// ==== hw/cpu_control_top.sv ====
`include "cpu_params.svh"

module cpu_control_top
(
	input logic clock,
	input logic cpucycle_rst,
	input logic [`CPU_WORD_W-1:0] pc,
	input logic [`CPU_WORD_W-1:0] brkpnt,
	input cpu_pkg::instr_t dec,
	input logic dec_valid,
	input cpu_pkg::flags_t alu_flags,
	input logic flags_valid,
	output logic dec_ready,
	output cpu_pkg::ctrl_word_t ctrl,
	output cpu_pkg::step_e step,
	output cpu_pkg::psw_t psw,
	output logic brk_hit
);
	import cpu_pkg::*;

	instr_t instr; // Latched instruction
	logic exec_allow;
	logic last_step;
	logic cex_consume;
	logic cond_true;
	logic cex_load;
	logic psw_op_en;

	cycle_sequencer u_seq
	(
		.clock(clock),
		.cpucycle_rst(cpucycle_rst),
		.pc(pc),
		.brkpnt(brkpnt),
		.dec(dec),
		.dec_valid(dec_valid),
		.exec_allow(exec_allow),
		.last_step(last_step),
		.dec_ready(dec_ready),
		.step(step),
		.instr(instr),
		.cex_consume(cex_consume),
		.brk_hit(brk_hit)
	);

	cond_eval u_cond
	(
		.instr(instr),
		.psw(psw),
		.cond_true(cond_true)
	);

	cex_tracker u_cex
	(
		.clock(clock),
		.cpucycle_rst(cpucycle_rst),
		.cex_load(cex_load),
		.cond_true(cond_true),
		.instr(instr),
		.cex_consume(cex_consume),
		.exec_allow(exec_allow)
	);

	psw_unit u_psw
	(
		.clock(clock),
		.cpucycle_rst(cpucycle_rst),
		.alu_flags(alu_flags),
		.flags_valid(flags_valid),
		.psw_op_en(psw_op_en),
		.instr(instr),
		.psw(psw)
	);

	ctrl_word_gen u_ctrl
	(
		.step(step),
		.instr(instr),
		.cond_true(cond_true),
		.ctrl(ctrl),
		.last_step(last_step),
		.cex_load(cex_load),
		.psw_op_en(psw_op_en)
	);
endmodule

// ==== hw/ctrl_word_gen.sv ====
`include "cpu_params.svh"

module ctrl_word_gen
(
	input cpu_pkg::step_e step,
	input cpu_pkg::instr_t instr,
	input logic cond_true,
	output cpu_pkg::ctrl_word_t ctrl,
	output logic last_step,
	output logic cex_load,
	output logic psw_op_en
);
	import cpu_pkg::*;

	logic [4:0] alu_idx; // ALU function before the byte bit
	logic [`CPU_RNUM_W-1:0] src_rn;
	logic [`CPU_RNUM_W-1:0] dst_rn;
	logic wb;

	function automatic bus_ctrl_t bus_path(input logic bw, input bus_port_e from, input bus_port_e to);
		bus_ctrl_t b;
		b.en = 1'b1;
		b.wb = bw;
		b.src = from;
		b.dst = to;
		return b;
	endfunction

	assign wb = instr.opnd.regop.wb;
	assign src_rn = {2'b00, instr.opnd.regop.src};
	assign dst_rn = {2'b00, instr.opnd.regop.dst};
	assign alu_idx = ((instr.op == SRA) || (instr.op == RRC)) ? 5'(instr.op - 7'd11)
		: 5'(instr.op - 7'd9); // Shifts follow BIS in the ALU table

	always_comb
	begin
		ctrl = '0; // Idle word
		last_step = 1'b0;
		cex_load = 1'b0;
		psw_op_en = 1'b0;
		case (step)
			FETCH1:
			begin
				ctrl.abus = bus_path(1'b0, REG, MDR); // PC to MAR
				ctrl.addr_src = `CPU_PC_REG;
				ctrl.mem = '{ena: 1'b1, rw: 1'b0, wb: 1'b0}; // Word read
				ctrl.alu_dst = `CPU_PC_REG; // ALU forms PC + 2
				ctrl.alu_src = `CPU_CONST2_REG;
			end
			FETCH2:
			begin
				ctrl.alu_dst = `CPU_PC_REG; // Keep PC + 2 on the ALU
				ctrl.alu_src = `CPU_CONST2_REG;
				ctrl.dbus = bus_path(1'b0, ALU, REG);
				ctrl.dbus_dst = `CPU_PC_REG;
			end
			FETCH3: ctrl.dbus = bus_path(1'b0, MDR, IR); // Instruction word into IR
			EXEC1:
			begin
				last_step = 1'b1; // Single step unless set back below
				case (instr.op)
					ADD, ADDC, SUB, SUBC, DADD, CMP, XOR, AND, OR, BIT, BIC, BIS, SRA, RRC:
					begin
						ctrl.alu_op = {alu_idx, wb};
						ctrl.alu_dst = dst_rn;
						ctrl.alu_src = src_rn + (instr.opnd.regop.rc ? 5'd8 : 5'd0); // Constants at 8 up
						ctrl.dbus = bus_path(wb, ALU, REG);
						ctrl.dbus_dst = dst_rn;
						ctrl.psw_update = 1'b1;
					end
					MOV:
					begin
						ctrl.dbus = bus_path(wb, REG, REG);
						ctrl.dbus_src = src_rn;
						ctrl.dbus_dst = dst_rn;
					end
					BEQ, BNE, BC, BNC, BN, BGE, BLT, BRA:
					begin
						if (cond_true) // Not taken leaves the word idle
						begin
							ctrl.s_sel = 1'b1; // PC + offset
							ctrl.alu_dst = `CPU_PC_REG;
							ctrl.dbus = bus_path(1'b0, ALU, REG);
							ctrl.dbus_dst = `CPU_PC_REG;
						end
					end
					BL:
					begin
						last_step = 1'b0;
						ctrl.dbus = bus_path(1'b0, REG, REG); // Return address to LR
						ctrl.dbus_src = `CPU_PC_REG;
						ctrl.dbus_dst = `CPU_LR_REG;
						ctrl.s_sel = 1'b1; // Target sum starts now
						ctrl.alu_dst = `CPU_PC_REG;
					end
					LD:
					begin
						last_step = 1'b0;
						ctrl.abus = bus_path(1'b0, REG, MDR); // Address reg to MAR
						ctrl.addr_src = src_rn;
						ctrl.mem = '{ena: 1'b1, rw: 1'b0, wb: wb};
					end
					ST:
					begin
						last_step = 1'b0;
						ctrl.abus = bus_path(1'b0, REG, MDR);
						ctrl.addr_src = dst_rn;
					end
					CEX: cex_load = 1'b1;
					SETPRI, SETCC, CLRCC: psw_op_en = 1'b1;
					default: ctrl = '0; // Unknown opcode does nothing
				endcase
			end
			EXEC2:
			begin
				last_step = 1'b1;
				case (instr.op)
					BL:
					begin
						ctrl.s_sel = 1'b1;
						ctrl.alu_dst = `CPU_PC_REG;
						ctrl.dbus = bus_path(1'b0, ALU, REG); // Branch target into PC
						ctrl.dbus_dst = `CPU_PC_REG;
					end
					LD:
					begin
						last_step = 1'b0;
						ctrl.dbus = bus_path(wb, MDR, REG); // Read data to dst
						ctrl.dbus_dst = dst_rn;
					end
					ST:
					begin
						last_step = 1'b0;
						ctrl.dbus = bus_path(wb, REG, MDR); // Store data to MDR
						ctrl.dbus_src = src_rn;
						ctrl.mem = '{ena: 1'b1, rw: 1'b1, wb: wb};
					end
					default: ctrl = '0;
				endcase
			end
			EXEC3: last_step = 1'b1; // Memory settles
			default: ctrl = '0; // Decode stays idle
		endcase
	end
endmodule

// ==== hw/psw_unit.sv ====
`include "cpu_params.svh"

module psw_unit
(
	input logic clock,
	input logic cpucycle_rst,
	input cpu_pkg::flags_t alu_flags,
	input logic flags_valid,
	input logic psw_op_en,
	input cpu_pkg::instr_t instr,
	output cpu_pkg::psw_t psw
);
	import cpu_pkg::*;

	logic [4:0] mask; // SETCC and CLRCC bit select
	logic [2:0] new_pri;

	assign mask = instr.opnd.pswop.pswb;
	assign new_pri = instr.opnd.pswop.pr;

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			psw <= psw_t'(`CPU_PSW_RESET);
		else
		begin
			if (flags_valid)
			begin
				psw.v <= alu_flags.v; // Flags from the ALU result
				psw.n <= alu_flags.n;
				psw.z <= alu_flags.z;
				psw.c <= alu_flags.c;
			end
			if (psw_op_en) // Later write wins over a same cycle flag load
			begin
				case (instr.op)
					SETCC: psw[4:0] <= psw[4:0] | mask;
					CLRCC: psw[4:0] <= psw[4:0] & ~mask;
					SETPRI:
					begin
						if (new_pri < psw.cur_pri)
							psw.cur_pri <= new_pri; // Priority can only drop
					end
					default: psw <= psw;
				endcase
			end
		end
	end
endmodule

// ==== hw/cex_tracker.sv ====
`include "cpu_params.svh"

module cex_tracker
(
	input logic clock,
	input logic cpucycle_rst,
	input logic cex_load,
	input logic cond_true,
	input cpu_pkg::instr_t instr,
	input logic cex_consume,
	output logic exec_allow
);
	logic active; // CEX block in progress
	logic result; // Condition outcome at the CEX
	logic [`CPU_CNT_W-1:0] true_cnt, false_cnt;
	logic [`CPU_CNT_W-1:0] true_nxt, false_nxt; // Counts after one instruction

	assign exec_allow = !active
		|| (result && (true_cnt != '0))
		|| (!result && (true_cnt == '0) && (false_cnt != '0));

	always_comb
	begin
		true_nxt = true_cnt;
		false_nxt = false_cnt;
		if (true_cnt != '0)
			true_nxt = true_cnt - 1'b1; // True slots go first
		else if (false_cnt != '0)
			false_nxt = false_cnt - 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			active <= 1'b0;
			result <= 1'b0;
			true_cnt <= '0;
			false_cnt <= '0;
		end
		else if (cex_load)
		begin
			active <= 1'b1;
			result <= cond_true;
			true_cnt <= instr.opnd.cexop.t;
			false_cnt <= instr.opnd.cexop.f;
		end
		else if (cex_consume)
		begin
			true_cnt <= true_nxt;
			false_cnt <= false_nxt;
			active <= active && ((true_nxt != '0) || (false_nxt != '0)); // Done when both run out
		end
	end
endmodule

// ==== hw/cond_eval.sv ====
module cond_eval
(
	input cpu_pkg::instr_t instr,
	input cpu_pkg::psw_t psw,
	output logic cond_true
);
	import cpu_pkg::*;

	logic [3:0] code; // Condition code under test

	always_comb
	begin
		case (instr.op)
			BEQ, BNE, BC, BNC, BN: code = 4'(instr.op - 7'd1); // EQ through MI
			BGE, BLT, BRA: code = 4'(instr.op + 7'd4); // GE through GT
			CEX: code = instr.opnd.cexop.c;
			default: code = 4'd15; // Never true
		endcase
	end

	always_comb
	begin
		case (code)
			4'd0: cond_true = psw.z; // EQ
			4'd1: cond_true = !psw.z; // NE
			4'd2: cond_true = psw.c; // CS
			4'd3: cond_true = !psw.c; // CC
			4'd4: cond_true = psw.n; // MI
			4'd5: cond_true = !psw.n; // PL
			4'd6: cond_true = psw.v; // VS
			4'd7: cond_true = !psw.v; // VC
			4'd8: cond_true = psw.c && !psw.z; // HI
			4'd9: cond_true = !psw.c || psw.z; // LS
			4'd10: cond_true = (psw.n == psw.v); // GE
			4'd11: cond_true = (psw.n != psw.v); // LT
			4'd12: cond_true = !psw.z && (psw.n == psw.v); // GT
			4'd13: cond_true = psw.z || (psw.n != psw.v); // LE
			4'd14: cond_true = 1'b1; // AL
			default: cond_true = 1'b0;
		endcase
	end
endmodule

// ==== hw/cycle_sequencer.sv ====
`include "cpu_params.svh"

module cycle_sequencer
(
	input logic clock,
	input logic cpucycle_rst,
	input logic [`CPU_WORD_W-1:0] pc,
	input logic [`CPU_WORD_W-1:0] brkpnt,
	input cpu_pkg::instr_t dec,
	input logic dec_valid,
	input logic exec_allow,
	input logic last_step,
	output logic dec_ready,
	output cpu_pkg::step_e step,
	output cpu_pkg::instr_t instr,
	output logic cex_consume,
	output logic brk_hit
);
	import cpu_pkg::*;

	step_e next_step;
	logic brk_match; // PC sits on the breakpoint
	logic handshake; // Decoded instruction taken this cycle

	assign brk_match = (pc == brkpnt);
	assign brk_hit = (step == FETCH1) && brk_match; // Only checked before a fetch
	assign dec_ready = (step == DECODE);
	assign handshake = dec_valid && dec_ready;
	assign cex_consume = handshake; // Every decoded instruction uses up one CEX slot

	always_comb
	begin
		next_step = step;
		case (step)
			FETCH1: next_step = brk_match ? FETCH1 : FETCH2; // Stall on breakpoint
			FETCH2: next_step = FETCH3;
			FETCH3: next_step = DECODE;
			DECODE:
			begin
				if (handshake)
					next_step = exec_allow ? EXEC1 : FETCH1; // Skipped under CEX
			end
			EXEC1, EXEC2: next_step = last_step ? FETCH1 : step_e'(step + 3'd1);
			default: next_step = FETCH1; // EXEC3 always ends the instruction
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			step <= FETCH1;
		else
			step <= next_step;
	end

	always_ff @(posedge clock)
	begin
		if (handshake)
			instr <= dec; // Held for the whole execute phase
	end
endmodule

// ==== hw/cpu_pkg.sv ====
`include "cpu_params.svh"

package cpu_pkg;
	typedef enum logic [6:0]
	{
		BL = 7'd0,
		BEQ = 7'd1, BNE = 7'd2, BC = 7'd3, BNC = 7'd4, // Branches on z and c
		BN = 7'd5, BGE = 7'd6, BLT = 7'd7, BRA = 7'd8, // Branches on n and v
		ADD = 7'd9, ADDC = 7'd10, SUB = 7'd11, SUBC = 7'd12,
		DADD = 7'd13, CMP = 7'd14, XOR = 7'd15, AND = 7'd16,
		OR = 7'd17, BIT = 7'd18, BIC = 7'd19, BIS = 7'd20,
		MOV = 7'd21,
		SRA = 7'd23, RRC = 7'd24, // Single operand shifts
		SETPRI = 7'd28,
		SETCC = 7'd30, CLRCC = 7'd31,
		CEX = 7'd32,
		LD = 7'd33, ST = 7'd34
	} opcode_e;

	typedef enum logic [2:0] {FETCH1, FETCH2, FETCH3, DECODE, EXEC1, EXEC2, EXEC3} step_e;

	typedef union packed
	{
		struct packed
		{
			logic [12:0] off; // Branch offset
		} branch;
		struct packed
		{
			logic [4:0] pad;
			logic rc; // Source is a constant
			logic wb; // Byte operation
			logic [2:0] src;
			logic [2:0] dst;
		} regop;
		struct packed
		{
			logic [12-4-2*`CPU_CNT_W:0] pad;
			logic [3:0] c; // Condition code
			logic [`CPU_CNT_W-1:0] t; // Instructions run on true
			logic [`CPU_CNT_W-1:0] f; // Instructions run on false
		} cexop;
		struct packed
		{
			logic [4:0] pad;
			logic [2:0] pr; // New priority
			logic [4:0] pswb; // PSW bit mask
		} pswop;
	} operand_u;

	typedef struct packed
	{
		opcode_e op;
		operand_u opnd;
	} instr_t;

	typedef struct packed
	{
		logic [2:0] prev_pri;
		logic [3:0] rsvd;
		logic flt;
		logic [2:0] cur_pri;
		logic v;
		logic slp;
		logic n;
		logic z;
		logic c;
	} psw_t;

	typedef struct packed
	{
		logic v;
		logic n;
		logic z;
		logic c;
	} flags_t;

	typedef enum logic [1:0] {MDR, REG, IR, ALU} bus_port_e; // MDR code also selects MAR

	typedef struct packed
	{
		logic en;
		logic wb;
		bus_port_e src;
		bus_port_e dst;
	} bus_ctrl_t;

	typedef struct packed
	{
		logic ena;
		logic rw; // High for a write
		logic wb;
	} mem_ctrl_t;

	typedef struct packed
	{
		bus_ctrl_t dbus;
		bus_ctrl_t abus;
		mem_ctrl_t mem;
		logic [5:0] alu_op;
		logic psw_update;
		logic s_sel; // ALU takes the sign extended offset
		logic [`CPU_RNUM_W-1:0] dbus_dst;
		logic [`CPU_RNUM_W-1:0] dbus_src;
		logic [`CPU_RNUM_W-1:0] alu_dst;
		logic [`CPU_RNUM_W-1:0] alu_src;
		logic [`CPU_RNUM_W-1:0] addr_src;
	} ctrl_word_t;
endpackage

// ==== include/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath word width
`define CPU_WORD_W 16

// Register number width. Number 16 selects the temp register
`define CPU_RNUM_W 5

// Register file numbers used by the control unit
`define CPU_PC_REG 5'd7
`define CPU_LR_REG 5'd5
`define CPU_CONST2_REG 5'd10

// PSW after reset with prev and cur priority at 3 and 7
`define CPU_PSW_RESET 16'h60E0

// Width of the CEX true and false counts
`define CPU_CNT_W 3

`endif
